//--- logic/lc3b_types_pkg.sv
package lc3b_types_pkg;

    typedef logic [15:0] lc3b_word;

    // Bit 2 is n, bit 1 is z, bit 0 is p, as in ir[11:9]
    typedef logic [2:0] lc3b_cc;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef struct packed {
        logic [1:0] cc_gen_mux_sel;           // 0 PCN, 1 ALU, 2 MDR, 3 SR2
        logic       cc_load;
        logic       data_memory_access;
        logic       data_memory_write_enable;
        logic       data_memory_word_align;   // Low means byte access
        logic [1:0] regfile_data_mux_sel;     // 0 PC, 1 PCN, 2 unused, 3 ALU
    } lc3b_control_word;

    // Counter index follows field order, i_cache_hit is counter 0
    typedef struct packed {
        logic i_cache_hit;
        logic d_cache_hit;
        logic l2_cache_hit;
        logic i_cache_miss;
        logic d_cache_miss;
        logic l2_cache_miss;
        logic if_stall;
        logic id_stall;
        logic ex_stall;
        logic mem_stall;
        logic wb_stall;
    } lc3b_debug_events;

    typedef enum logic [1:0] {
        addr_trapvect = 2'd0,
        addr_alu      = 2'd1,
        addr_mdr      = 2'd2
    } lc3b_addr_sel;

endpackage

//--- logic/wb_bus_pkg.sv
package wb_bus_pkg;

    localparam int wb_line_bytes = 16;
    localparam int wb_line_bits  = wb_line_bytes * 8;

    // 16-bit byte address minus the 4 offset bits
    localparam int wb_adr_bits = 12;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [wb_adr_bits-1:0]   adr;   // Line address
        logic [wb_line_bytes-1:0] sel;   // One bit per byte lane
        logic [wb_line_bits-1:0]  dat;
    } wb_m2s;

    typedef struct packed {
        logic                    ack;
        logic [wb_line_bits-1:0] dat;
    } wb_s2m;

endpackage

//--- logic/mem_access_controller.sv
`timescale 1ns/1ps

module mem_access_controller (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stall,
    input  lc3b_types_pkg::lc3b_control_word  control_in,
    input  lc3b_types_pkg::lc3b_word          ir_in,
    input  logic                              ack,
    output lc3b_types_pkg::lc3b_addr_sel      addr_sel,
    output logic                              write_enable,
    output logic                              mdr_load,
    output logic                              request_stall
);

    lc3b_types_pkg::lc3b_opcode opcode;
    logic                       indirect;
    logic                       phase_two;
    logic                       final_ack;

    assign opcode   = lc3b_types_pkg::lc3b_opcode'(ir_in[15:12]);
    assign indirect = control_in.data_memory_access &&
                      (opcode == lc3b_types_pkg::op_ldi || opcode == lc3b_types_pkg::op_sti);

    always_comb begin
        addr_sel     = lc3b_types_pkg::addr_alu;
        write_enable = control_in.data_memory_write_enable;
        mdr_load     = 1'b0;
        if (opcode == lc3b_types_pkg::op_trap) begin
            addr_sel = lc3b_types_pkg::addr_trapvect;
        end
        if (indirect) begin
            if (phase_two) begin
                addr_sel = lc3b_types_pkg::addr_mdr;   // Follow the pointer
            end else begin
                write_enable = 1'b0;                   // Pointer fetch is always a read
                mdr_load     = ack;
            end
        end
    end

    // Single accesses finish on their ack, indirect ones on the second
    assign final_ack     = ack && (!indirect || phase_two);
    assign request_stall = control_in.data_memory_access && !final_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_two <= 1'b0;
        end else if (!stall && indirect && ack) begin
            phase_two <= !phase_two;
        end
    end

endmodule

//--- logic/performance_counters.sv
`timescale 1ns/1ps

module performance_counters #(
    parameter lc3b_types_pkg::lc3b_word counter_base = 16'hFFE0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              access,
    input  logic                              write_enable,
    input  lc3b_types_pkg::lc3b_word          address,
    input  lc3b_types_pkg::lc3b_debug_events  debug_events,
    output logic                              access_cancel,
    output lc3b_types_pkg::lc3b_word          count_out
);

    localparam int num_counters = 11;

    lc3b_types_pkg::lc3b_word counts [num_counters];
    lc3b_types_pkg::lc3b_word offset;
    logic [14:0]              index;
    logic                     in_window;
    logic                     index_valid;
    logic [num_counters-1:0]  events;

    // Index 0 is the instruction cache hit, index 10 the WB stall
    assign events = {
        debug_events.wb_stall,
        debug_events.mem_stall,
        debug_events.ex_stall,
        debug_events.id_stall,
        debug_events.if_stall,
        debug_events.l2_cache_miss,
        debug_events.d_cache_miss,
        debug_events.i_cache_miss,
        debug_events.l2_cache_hit,
        debug_events.d_cache_hit,
        debug_events.i_cache_hit
    };

    assign offset      = address - counter_base;
    assign index       = offset[15:1];                 // Word index into the window
    assign in_window   = (address >= counter_base);
    assign index_valid = in_window && (index < 15'(num_counters));

    assign access_cancel = access && in_window;

    always_comb begin
        count_out = '0;
        if (index_valid) begin
            count_out = counts[index[3:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_counters; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_counters; i++) begin
                if (access_cancel && write_enable && index_valid && index[3:0] == 4'(i)) begin
                    counts[i] <= '0;                   // Clear wins over this cycle's event
                end else if (events[i] && counts[i] != 16'hFFFF) begin
                    counts[i] <= counts[i] + 16'd1;
                end
            end
        end
    end

endmodule

//--- logic/stage_mem.sv
`timescale 1ns/1ps

module stage_mem #(
    parameter lc3b_types_pkg::lc3b_word counter_base = 16'hFFE0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stall,
    input  lc3b_types_pkg::lc3b_control_word  control_in,
    input  lc3b_types_pkg::lc3b_word          ir_in,
    input  lc3b_types_pkg::lc3b_word          alu_in,
    input  lc3b_types_pkg::lc3b_word          pc_in,
    input  lc3b_types_pkg::lc3b_word          pcn_in,
    input  lc3b_types_pkg::lc3b_word          sr2_in,
    input  lc3b_types_pkg::lc3b_debug_events  debug_events,
    output lc3b_types_pkg::lc3b_word          mdr_out,
    output lc3b_types_pkg::lc3b_word          regfile_data_out,
    output logic                              br_en_out,
    output logic                              request_stall,
    output wb_bus_pkg::wb_m2s                 bus_req,
    input  wb_bus_pkg::wb_s2m                 bus_rsp
);

    lc3b_types_pkg::lc3b_addr_sel addr_sel;
    lc3b_types_pkg::lc3b_word     address;
    lc3b_types_pkg::lc3b_word     trapvect;
    lc3b_types_pkg::lc3b_word     internal_mdr;
    lc3b_types_pkg::lc3b_word     count_out;
    lc3b_types_pkg::lc3b_word     cc_src;
    lc3b_types_pkg::lc3b_cc       cc_gen;
    lc3b_types_pkg::lc3b_cc       cc;
    logic                         write_enable;
    logic                         mdr_load;
    logic                         access_cancel;
    logic                         access_done;

    assign trapvect = {7'b0, ir_in[7:0], 1'b0};

    // Counter accesses complete at once, with no bus cycle
    assign access_done = bus_rsp.ack || access_cancel;

    mem_access_controller u_controller (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .control_in    (control_in),
        .ir_in         (ir_in),
        .ack           (access_done),
        .addr_sel      (addr_sel),
        .write_enable  (write_enable),
        .mdr_load      (mdr_load),
        .request_stall (request_stall)
    );

    always_comb begin
        case (addr_sel)
            lc3b_types_pkg::addr_trapvect: address = trapvect;
            lc3b_types_pkg::addr_mdr:      address = internal_mdr;
            default:                       address = alu_in;
        endcase
    end

    performance_counters #(
        .counter_base (counter_base)
    ) u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .access        (control_in.data_memory_access),
        .write_enable  (write_enable),
        .address       (address),
        .debug_events  (debug_events),
        .access_cancel (access_cancel),
        .count_out     (count_out)
    );

    always_comb begin
        bus_req     = '0;
        bus_req.cyc = control_in.data_memory_access && !access_cancel;
        bus_req.stb = control_in.data_memory_access && !access_cancel;
        bus_req.we  = write_enable;
        bus_req.adr = address[15:4];
        if (control_in.data_memory_word_align) begin
            bus_req.sel[address[3:1]*2 +: 2]  = 2'b11;
            bus_req.dat[address[3:1]*16 +: 16] = sr2_in;
        end else begin
            bus_req.sel[address[3:1]*2 +: 2]  = address[0] ? 2'b10 : 2'b01;
            bus_req.dat[address[3:1]*16 +: 16] = {sr2_in[7:0], sr2_in[7:0]};  // Same byte in both halves
        end
    end

    always_comb begin
        if (access_cancel) begin
            mdr_out = count_out;
        end else if (control_in.data_memory_word_align) begin
            mdr_out = bus_rsp.dat[address[3:1]*16 +: 16];
        end else begin
            mdr_out = {8'b0, bus_rsp.dat[address[3:0]*8 +: 8]};
        end
    end

    always_ff @(posedge clk) begin
        if (mdr_load && !stall) begin
            internal_mdr <= mdr_out;                   // Pointer for LDI and STI
        end
    end

    always_comb begin
        case (control_in.cc_gen_mux_sel)
            2'd0:    cc_src = pcn_in;
            2'd1:    cc_src = alu_in;
            2'd2:    cc_src = mdr_out;
            default: cc_src = sr2_in;
        endcase
    end

    always_comb begin
        if (cc_src[15]) begin
            cc_gen = 3'b100;
        end else if (cc_src == '0) begin
            cc_gen = 3'b010;
        end else begin
            cc_gen = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc <= '0;
        end else if (control_in.cc_load && !stall) begin
            cc <= cc_gen;
        end
    end

    assign br_en_out = |(cc & ir_in[11:9]);

    // Same selection as the writeback mux, minus the MDR input
    always_comb begin
        case (control_in.regfile_data_mux_sel)
            2'd0:    regfile_data_out = pc_in;
            2'd1:    regfile_data_out = pcn_in;
            2'd3:    regfile_data_out = alu_in;
            default: regfile_data_out = '0;
        endcase
    end

endmodule

//--- logic/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int memory_lines = 4096
) (
    input  logic              clk,
    input  logic              rst_n,
    input  wb_bus_pkg::wb_m2s bus_req,
    output wb_bus_pkg::wb_s2m bus_rsp
);

    localparam int index_bits = $clog2(memory_lines);

    logic [wb_bus_pkg::wb_line_bits-1:0] lines [memory_lines];
    logic [wb_bus_pkg::wb_line_bits-1:0] read_line;
    logic [index_bits-1:0]               index;
    logic                                ack;
    logic                                sample;

    assign index  = bus_req.adr[index_bits-1:0];
    assign sample = bus_req.cyc && bus_req.stb && !ack;   // New request this edge

    always_ff @(posedge clk) begin
        if (sample) begin
            read_line <= lines[index];
            if (bus_req.we) begin
                for (int b = 0; b < wb_bus_pkg::wb_line_bytes; b++) begin
                    if (bus_req.sel[b]) begin
                        lines[index][b*8 +: 8] <= bus_req.dat[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= sample;                             // High for one cycle
        end
    end

    assign bus_rsp.ack = ack;
    assign bus_rsp.dat = read_line;

endmodule

//--- logic/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top #(
    parameter lc3b_types_pkg::lc3b_word counter_base = 16'hFFE0,
    parameter int                       memory_lines = 4096
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stall,
    input  lc3b_types_pkg::lc3b_control_word  control_in,
    input  lc3b_types_pkg::lc3b_word          ir_in,
    input  lc3b_types_pkg::lc3b_word          alu_in,
    input  lc3b_types_pkg::lc3b_word          pc_in,
    input  lc3b_types_pkg::lc3b_word          pcn_in,
    input  lc3b_types_pkg::lc3b_word          sr2_in,
    input  lc3b_types_pkg::lc3b_debug_events  debug_events,
    output lc3b_types_pkg::lc3b_word          mdr_out,
    output lc3b_types_pkg::lc3b_word          regfile_data_out,
    output logic                              br_en_out,
    output logic                              request_stall
);

    wb_bus_pkg::wb_m2s bus_req;
    wb_bus_pkg::wb_s2m bus_rsp;

    stage_mem #(
        .counter_base (counter_base)
    ) u_stage_mem (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall            (stall),
        .control_in       (control_in),
        .ir_in            (ir_in),
        .alu_in           (alu_in),
        .pc_in            (pc_in),
        .pcn_in           (pcn_in),
        .sr2_in           (sr2_in),
        .debug_events     (debug_events),
        .mdr_out          (mdr_out),
        .regfile_data_out (regfile_data_out),
        .br_en_out        (br_en_out),
        .request_stall    (request_stall),
        .bus_req          (bus_req),
        .bus_rsp          (bus_rsp)
    );

    data_memory #(
        .memory_lines (memory_lines)
    ) u_data_memory (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

//--- test/mem_subsystem_assertions.sv
`timescale 1ns/1ps

module mem_subsystem_assertions #(
    parameter lc3b_types_pkg::lc3b_word counter_base = 16'hFFE0
) (
    input logic                             clk,
    input logic                             rst_n,
    input lc3b_types_pkg::lc3b_control_word control_in,
    input lc3b_types_pkg::lc3b_word         address,
    input wb_bus_pkg::wb_m2s                bus_req,
    input wb_bus_pkg::wb_s2m                bus_rsp,
    input logic                             access_cancel,
    input logic                             request_stall
);

    ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.ack |-> $past(bus_req.stb))
        else $error("ack without a strobe in the cycle before");

    // Counter window addresses never reach the bus
    no_stb_in_counter_window: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.stb |-> (address < counter_base))
        else $error("strobe raised for a counter window access");

    // Stall may only drop on completion or when the request goes away
    stall_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(request_stall) |->
            (bus_rsp.ack || access_cancel || !control_in.data_memory_access))
        else $error("request_stall fell with no ack and the request still up");

    cyc_equals_stb: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.cyc == bus_req.stb)
        else $error("cyc and stb differ");

endmodule

//--- test/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam lc3b_types_pkg::lc3b_word counter_base = 16'hFFE0;
    localparam int fill_words    = 256;
    localparam int mixed_ops     = 60;
    localparam int indirect_ops  = 20;
    localparam int trap_ops      = 10;
    localparam int cc_ops        = 16;
    localparam int forward_ops   = 6;
    localparam int counter_ops   = 10;
    localparam int total_ops     = fill_words + mixed_ops + indirect_ops * 4 + trap_ops
                                   + cc_ops * 2 + forward_ops + counter_ops * 6 + 20;
    localparam time watchdog_ns  = total_ops * 6 * 20;

    typedef struct {
        string                    name;
        lc3b_types_pkg::lc3b_word expected;
        lc3b_types_pkg::lc3b_word actual;
        time                      t;
    } check_rec;

    logic                             clk;
    logic                             rst_n;
    logic                             stall;
    lc3b_types_pkg::lc3b_control_word control_in;
    lc3b_types_pkg::lc3b_word         ir_in;
    lc3b_types_pkg::lc3b_word         alu_in;
    lc3b_types_pkg::lc3b_word         pc_in;
    lc3b_types_pkg::lc3b_word         pcn_in;
    lc3b_types_pkg::lc3b_word         sr2_in;
    lc3b_types_pkg::lc3b_debug_events debug_events;
    lc3b_types_pkg::lc3b_word         mdr_out;
    lc3b_types_pkg::lc3b_word         regfile_data_out;
    logic                             br_en_out;
    logic                             request_stall;

    logic [31:0]              lfsr_state   = 32'h97c12cb3;
    logic [31:0]              events_state = 32'h97c12cb3;
    logic [7:0]               mem_model [512];   // Bytes 0x000 to 0x1FF
    lc3b_types_pkg::lc3b_word counts_model [11];
    lc3b_types_pkg::lc3b_cc   model_cc;
    logic                     events_on;
    check_rec                 check_q [$];
    int                       checks;
    int                       errors;

    mem_subsystem_top #(
        .counter_base (counter_base),
        .memory_lines (4096)
    ) uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall            (stall),
        .control_in       (control_in),
        .ir_in            (ir_in),
        .alu_in           (alu_in),
        .pc_in            (pc_in),
        .pcn_in           (pcn_in),
        .sr2_in           (sr2_in),
        .debug_events     (debug_events),
        .mdr_out          (mdr_out),
        .regfile_data_out (regfile_data_out),
        .br_en_out        (br_en_out),
        .request_stall    (request_stall)
    );

    bind stage_mem mem_subsystem_assertions #(.counter_base(counter_base)) u_assertions (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic lc3b_types_pkg::lc3b_word model_word(input lc3b_types_pkg::lc3b_word a);
        return {mem_model[{a[8:1], 1'b1}], mem_model[{a[8:1], 1'b0}]};
    endfunction

    function automatic lc3b_types_pkg::lc3b_cc cc_of(input lc3b_types_pkg::lc3b_word v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    function automatic lc3b_types_pkg::lc3b_word expected_forward(input logic [1:0] sel,
            input lc3b_types_pkg::lc3b_word pc, input lc3b_types_pkg::lc3b_word pcn,
            input lc3b_types_pkg::lc3b_word alu);
        case (sel)
            2'd0:    return pc;
            2'd1:    return pcn;
            2'd3:    return alu;
            default: return 16'h0000;
        endcase
    endfunction

    function automatic lc3b_types_pkg::lc3b_control_word make_ctrl(input logic access,
            input logic we, input logic word, input logic cc_load, input logic [1:0] cc_sel,
            input logic [1:0] rf_sel);
        lc3b_types_pkg::lc3b_control_word cw;
        cw.cc_gen_mux_sel           = cc_sel;
        cw.cc_load                  = cc_load;
        cw.data_memory_access       = access;
        cw.data_memory_write_enable = we;
        cw.data_memory_word_align   = word;
        cw.regfile_data_mux_sel     = rf_sel;
        return cw;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Counter model, sees the inputs that were applied before this edge
    always @(posedge clk) begin
        lc3b_types_pkg::lc3b_word idx;
        idx = (alu_in - counter_base) >> 1;
        for (int i = 0; i < 11; i++) begin
            if (!rst_n) begin
                counts_model[i] = '0;
            end else if (control_in.data_memory_access && control_in.data_memory_write_enable
                         && alu_in >= counter_base && idx == i) begin
                counts_model[i] = '0;
            end else if (debug_events[10-i] && counts_model[i] != 16'hFFFF) begin
                counts_model[i] = counts_model[i] + 16'd1;
            end
        end
    end

    always @(posedge clk) begin
        logic [10:0] ev;
        ev = '0;
        if (events_on) begin
            for (int i = 0; i < 11; i++) begin
                events_state = lfsr_step(events_state);
                ev = {ev[9:0], events_state[0]};
            end
        end
        debug_events <= ev;
    end

    // Compare process
    initial begin
        check_rec rec;
        forever begin
            wait (check_q.size() != 0);
            rec = check_q.pop_front();
            checks++;
            assert (rec.actual === rec.expected) else begin
                errors++;
                $display("Mismatch at %0t: %s expected %h got %h",
                         rec.t, rec.name, rec.expected, rec.actual);
            end
        end
    end

    initial begin
        #(watchdog_ns * 1ns);
        $display("Timeout: the run did not finish within %0t", watchdog_ns * 1ns);
        $display("Verification failed");
        $finish;
    end

    task automatic push_check(input string name, input lc3b_types_pkg::lc3b_word exp,
                              input lc3b_types_pkg::lc3b_word act);
        check_rec rec;
        rec.name     = name;
        rec.expected = exp;
        rec.actual   = act;
        rec.t        = $time;
        check_q.push_back(rec);
    endtask

    // Returns at the falling edge of the cycle where the access completes
    task automatic run_access(input lc3b_types_pkg::lc3b_control_word cw,
            input lc3b_types_pkg::lc3b_word ir, input lc3b_types_pkg::lc3b_word alu,
            input lc3b_types_pkg::lc3b_word sr2, output lc3b_types_pkg::lc3b_word data,
            output int stall_cycles);
        @(posedge clk);
        control_in <= cw;
        ir_in      <= ir;
        alu_in     <= alu;
        sr2_in     <= sr2;
        stall_cycles = 0;
        @(negedge clk);
        while (request_stall && stall_cycles < 8) begin
            stall_cycles++;
            @(negedge clk);
        end
        if (request_stall) begin
            errors++;
            $display("request_stall never fell for the access at address %h", alu);
        end
        data = mdr_out;
    endtask

    task automatic release_bus();
        @(posedge clk);
        control_in <= make_ctrl(0, 0, 0, 0, 0, 0);
    endtask

    task automatic mem_op(input int kind, input lc3b_types_pkg::lc3b_word addr,
                          input lc3b_types_pkg::lc3b_word data);
        lc3b_types_pkg::lc3b_word got;
        int                       stalls;
        case (kind)
            0: begin
                run_access(make_ctrl(1, 1, 1, 0, 0, 0), 16'h7000, addr, data, got, stalls);
                mem_model[{addr[8:1], 1'b0}] = data[7:0];
                mem_model[{addr[8:1], 1'b1}] = data[15:8];
            end
            1: begin
                run_access(make_ctrl(1, 0, 1, 0, 0, 0), 16'h6000, addr, 16'h0, got, stalls);
                push_check("mdr_out word load", model_word(addr), got);
            end
            2: begin
                run_access(make_ctrl(1, 1, 0, 0, 0, 0), 16'h3000, addr, data, got, stalls);
                mem_model[addr[8:0]] = data[7:0];
            end
            default: begin
                run_access(make_ctrl(1, 0, 0, 0, 0, 0), 16'h2000, addr, 16'h0, got, stalls);
                push_check("mdr_out byte load", {8'h00, mem_model[addr[8:0]]}, got);
            end
        endcase
        push_check("request_stall cycles", 16'd1, 16'(stalls));
        release_bus();
    endtask

    task automatic check_branch();
        logic [2:0] nzp;
        nzp = random_bits(3);
        @(posedge clk);
        ir_in <= {4'h0, nzp, 9'h000};
        @(negedge clk);
        push_check("br_en_out", {15'h0, |(model_cc & nzp)}, {15'h0, br_en_out});
    endtask

    initial begin
        lc3b_types_pkg::lc3b_word got;
        lc3b_types_pkg::lc3b_word addr;
        lc3b_types_pkg::lc3b_word target;
        lc3b_types_pkg::lc3b_word value;
        lc3b_types_pkg::lc3b_word pc_v;
        lc3b_types_pkg::lc3b_word pcn_v;
        lc3b_types_pkg::lc3b_word alu_v;
        int                       stalls;
        int                       idx;
        logic [1:0]               sel;
        logic                     hold;

        rst_n        = 1'b0;
        stall        = 1'b0;
        control_in   = make_ctrl(0, 0, 0, 0, 0, 0);
        ir_in        = 16'h0E00;   // n, z and p all enabled
        alu_in       = '0;
        pc_in        = '0;
        pcn_in       = '0;
        sr2_in       = '0;
        debug_events = '0;
        events_on    = 1'b0;
        model_cc     = '0;
        checks       = 0;
        errors       = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        push_check("br_en_out after reset", 16'h0, {15'h0, br_en_out});

        for (int i = 0; i < fill_words; i++) begin
            mem_op(0, 16'(i * 2), random_bits(16));
        end

        for (int i = 0; i < mixed_ops; i++) begin
            idx  = random_bits(2);
            addr = random_bits(9);
            if (idx < 2) addr[0] = 1'b0;     // Word accesses stay aligned
            mem_op(idx, addr, random_bits(16));
        end

        for (int i = 0; i < indirect_ops; i++) begin
            addr   = {random_bits(8), 1'b0};
            target = {random_bits(8), 1'b0};
            if (target == addr) target = addr ^ 16'h0002;
            mem_op(0, addr, target);
            if (i % 2 == 0) begin
                run_access(make_ctrl(1, 0, 1, 0, 0, 0), 16'hA000, addr, 16'h0, got, stalls);
                push_check("mdr_out LDI", model_word(target), got);
                push_check("request_stall cycles LDI", 16'd3, 16'(stalls));
                release_bus();
            end else begin
                value = random_bits(16);
                run_access(make_ctrl(1, 1, 1, 0, 0, 0), 16'hB000, addr, value, got, stalls);
                push_check("request_stall cycles STI", 16'd3, 16'(stalls));
                release_bus();
                mem_model[target[8:0]]          = value[7:0];
                mem_model[{target[8:1], 1'b1}]  = value[15:8];
                mem_op(1, addr, 16'h0);     // Pointer must be unchanged
                mem_op(1, target, 16'h0);
            end
        end

        for (int i = 0; i < trap_ops; i++) begin
            value = random_bits(8);
            run_access(make_ctrl(1, 0, 1, 0, 0, 0), {8'hF0, value[7:0]}, 16'h0, 16'h0,
                       got, stalls);
            push_check("mdr_out TRAP", model_word({value[7:0], 1'b0}), got);
            push_check("request_stall cycles TRAP", 16'd1, 16'(stalls));
            release_bus();
        end

        for (int i = 0; i < cc_ops; i++) begin
            sel = random_bits(2);
            if (sel == 2'd2) begin
                addr = {random_bits(8), 1'b0};
                run_access(make_ctrl(1, 0, 1, 1, 2, 0), 16'h6000, addr, 16'h0, got, stalls);
                release_bus();
                model_cc = cc_of(model_word(addr));
            end else begin
                value = random_bits(16);
                if (random_bits(3) == 0) value = 16'h0000;
                hold = (random_bits(2) == 0);
                @(posedge clk);
                control_in <= make_ctrl(0, 0, 0, 1, sel, 0);
                pcn_in     <= (sel == 2'd0) ? value : ~value;   // Other sources give another CC
                alu_in     <= (sel == 2'd1) ? value : ~value;
                sr2_in     <= (sel == 2'd3) ? value : ~value;
                stall      <= hold;
                @(posedge clk);
                control_in <= make_ctrl(0, 0, 0, 0, 0, 0);
                stall      <= 1'b0;
                if (!hold) model_cc = cc_of(value);
            end
            check_branch();
        end

        for (int i = 0; i < forward_ops; i++) begin
            sel   = (i % 3 == 2) ? 2'd3 : 2'(i % 3);
            pc_v  = random_bits(16);
            pcn_v = random_bits(16);
            alu_v = random_bits(16);
            @(posedge clk);
            control_in <= make_ctrl(0, 0, 0, 0, 0, sel);
            pc_in      <= pc_v;
            pcn_in     <= pcn_v;
            alu_in     <= alu_v;
            @(negedge clk);
            push_check("regfile_data_out", expected_forward(sel, pc_v, pcn_v, alu_v),
                       regfile_data_out);
        end

        events_on = 1'b1;
        for (int i = 0; i < counter_ops; i++) begin
            repeat (random_bits(3)) @(posedge clk);
            idx  = random_bits(4) % 11;
            addr = counter_base + 16'(idx * 2);
            run_access(make_ctrl(1, 0, 1, 0, 0, 0), 16'h6000, addr, 16'h0, got, stalls);
            push_check("counter load", counts_model[idx], got);
            push_check("request_stall cycles counter", 16'd0, 16'(stalls));
            release_bus();
            run_access(make_ctrl(1, 1, 1, 0, 0, 0), 16'h7000, addr, random_bits(16),
                       got, stalls);
            push_check("request_stall cycles counter clear", 16'd0, 16'(stalls));
            release_bus();
            repeat (random_bits(2)) @(posedge clk);
            run_access(make_ctrl(1, 0, 1, 0, 0, 0), 16'h6000, addr, 16'h0, got, stalls);
            push_check("counter load after clear", counts_model[idx], got);
            release_bus();
        end
        run_access(make_ctrl(1, 0, 1, 0, 0, 0), 16'h6000, counter_base + 16'd24, 16'h0,
                   got, stalls);
        push_check("counter load past last index", 16'h0000, got);
        release_bus();
        events_on = 1'b0;

        repeat (2) @(posedge clk);
        wait (check_q.size() == 0);
        #1;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- project.f
logic/lc3b_types_pkg.sv
logic/wb_bus_pkg.sv
logic/mem_access_controller.sv
logic/performance_counters.sv
logic/stage_mem.sv
logic/data_memory.sv
logic/mem_subsystem_top.sv
test/mem_subsystem_assertions.sv
test/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - logic/lc3b_types_pkg.sv
      - logic/wb_bus_pkg.sv
      - logic/mem_access_controller.sv
      - logic/performance_counters.sv
      - logic/stage_mem.sv
      - logic/data_memory.sv
      - logic/mem_subsystem_top.sv
  - target: test
    files:
      - test/mem_subsystem_assertions.sv
      - test/tb_mem_subsystem.sv
